// File: verilog/sme_params.svh
`ifndef SME_PARAMS_SVH
`define SME_PARAMS_SVH

// Stream geometry

// Bytes per beat, sets data and keep widths
`define SME_BYTES 8

// Fast pattern length in bytes
`define SME_PAT_LEN 4

// Matcher output

// Rule ID width, zero means no match
`define SME_RULE_W 16

// FIFO address width, 4 entries
`define SME_FIFO_AW 2

// Preamble carried between packets of one flow

// Bytes kept from the end of a packet
`define SME_TAIL_BYTES 7

`endif

// File: verilog/sme_pkg.sv
`default_nettype none

`include "sme_params.svh"

package sme_pkg;

  // One stream beat, byte 0 in data[7:0] is the earliest byte
  typedef struct packed {
    logic [8*`SME_BYTES-1:0] data;
    logic [`SME_BYTES-1:0]   keep;
    logic                    last;
  } sme_beat_t;

  // Rule IDs per lane, lane k ends on byte k of the beat
  typedef struct packed {
    logic [`SME_BYTES-1:0][`SME_RULE_W-1:0] rule;
  } sme_lanes_t;

  // Preamble or saved tail, lowest byte is the oldest
  typedef struct packed {
    logic [8*`SME_TAIL_BYTES-1:0] bytes;
    logic [2:0]                   count;
    logic                         valid;
  } sme_tail_t;

endpackage

`default_nettype wire

// File: verilog/chunk_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module chunk_mux
  import sme_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      reload,
  input  sme_tail_t preamble,
  input  sme_beat_t s_beat,
  input  logic      s_valid,
  output logic      s_ready,
  input  logic      in_ready,
  output sme_beat_t m_beat,
  output logic      m_valid,
  output logic      m_sop,
  output logic      m_pre
);

  localparam int PAD_BITS = 8 * (`SME_BYTES - `SME_TAIL_BYTES);

  logic pre_pend;
  logic sop_pend;
  logic m_fire;

  assign m_fire = m_valid && in_ready;

  //////////////////////////////
  // Preamble and start of flow
  //////////////////////////////

  // Preamble chunk goes out once after a reload that carries one
  always_ff @(posedge clk) begin
    if (rst) begin
      pre_pend <= 1'b0;
    end else if (reload) begin
      pre_pend <= preamble.valid;
    end else if (pre_pend && in_ready) begin
      pre_pend <= 1'b0;
    end
  end

  // Start of flow rides on the first chunk after reload
  always_ff @(posedge clk) begin
    if (rst) begin
      sop_pend <= 1'b0;
    end else if (reload) begin
      sop_pend <= 1'b1;
    end else if (m_fire) begin
      sop_pend <= 1'b0;
    end
  end

  //////////////////////////////
  // Chunk select
  //////////////////////////////

  // Newest preamble byte lands in the top lane so history picks it up
  always_comb begin
    if (pre_pend) begin
      m_beat.data = {preamble.bytes, {PAD_BITS{1'b0}}};
      m_beat.keep = '1;
      m_beat.last = 1'b0;
    end else begin
      m_beat = s_beat;
    end
  end

  assign m_valid = pre_pend || s_valid;
  assign m_pre   = pre_pend;
  assign m_sop   = sop_pend;
  assign s_ready = !pre_pend && in_ready;

endmodule

`default_nettype wire

// File: verilog/pattern_matcher.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module pattern_matcher
  import sme_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  sme_beat_t  m_beat,
  input  logic       m_valid,
  input  logic       m_sop,
  input  logic       m_pre,
  output logic       in_ready,
  input  logic       almost_full,
  output logic       push,
  output sme_lanes_t lanes
);

  localparam int NB   = `SME_BYTES;
  localparam int HB   = `SME_PAT_LEN - 1;
  localparam int WB   = NB + HB;
  localparam int PW   = 8 * `SME_PAT_LEN;
  localparam int RW   = `SME_RULE_W;
  localparam int NPAT = 8;

  // Patterns in stream order, lowest byte first, rule ID is index plus one
  localparam logic [PW-1:0] PAT_TABLE [NPAT] = '{
    32'h4443_4241,
    32'h4544_4342,
    32'h4645_4443,
    32'h4746_4544,
    32'h4847_4645,
    32'h4948_4746,
    32'h4A49_4847,
    32'h4B4A_4948
  };

  logic            fire;
  logic [8*HB-1:0] hist_q;
  logic [8*HB-1:0] hist_eff;
  logic [8*WB-1:0] win_q;
  logic [NB-1:0]   keep_q;
  logic            s1_valid;
  logic            s1_pre;
  sme_lanes_t      lanes_d;
  logic            any_hit;

  assign fire = m_valid && in_ready;

  // Two results may still be headed for the FIFO behind almost_full
  assign in_ready = !almost_full && !(push && s1_valid && !s1_pre);

  //////////////////////////////
  // Stage 1 window
  //////////////////////////////

  // New flow without preamble starts from an empty history
  assign hist_eff = m_sop ? '0 : hist_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      hist_q   <= '0;
    end else begin
      s1_valid <= fire;
      if (fire) begin
        if (m_beat.last) begin
          hist_q <= '0;
        end else begin
          hist_q <= m_beat.data[8*NB-1 -: 8*HB];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      win_q  <= {m_beat.data, hist_eff};
      keep_q <= m_beat.keep;
      s1_pre <= m_pre;
    end
  end

  //////////////////////////////
  // Stage 2 compare
  //////////////////////////////

  // Lane k looks at window bytes k to k+3, its last byte is beat byte k
  always_comb begin
    lanes_d = '0;
    for (int k = 0; k < NB; k++) begin
      for (int p = 0; p < NPAT; p++) begin
        if (keep_q[k] && win_q[8*k +: PW] == PAT_TABLE[p]) begin
          lanes_d.rule[k] = RW'(p + 1);
        end
      end
    end
  end

  assign any_hit = |lanes_d.rule;

  always_ff @(posedge clk) begin
    if (rst) begin
      push <= 1'b0;
    end else begin
      push <= s1_valid && !s1_pre && any_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      lanes <= lanes_d;
    end
  end

  // Short keep only on the packet end, and packed from byte 0
  assert property (@(posedge clk) disable iff (rst)
    (fire && !m_pre && m_beat.keep != '1) |->
      (m_beat.last && (m_beat.keep & (m_beat.keep + 1'b1)) == '0));

endmodule

`default_nettype wire

// File: verilog/match_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module match_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     clear,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     not_empty,
  output logic     almost_full
);

  localparam int AW    = `SME_FIFO_AW;
  localparam int CW    = AW + 1;
  localparam int DEPTH = 1 << AW;

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  //////////////////////////////
  // Pointers and fill level
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  assign dout        = mem[rd_ptr];
  assign not_empty   = count != '0;
  assign almost_full = count >= CW'(DEPTH - 1);

  assert property (@(posedge clk) disable iff (rst || clear)
    push |-> count != CW'(DEPTH));

  assert property (@(posedge clk) disable iff (rst || clear)
    pop |-> count != '0);

endmodule

`default_nettype wire

// File: verilog/match_selector.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module match_selector
  import sme_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reload,
  input  sme_lanes_t            dout,
  input  logic                  not_empty,
  output logic                  pop,
  input  logic                  next_index,
  output logic [`SME_RULE_W-1:0] match_index,
  output logic                  match_valid,
  output logic [`SME_BYTES-1:0] match_valid_stat
);

  localparam int NB = `SME_BYTES;

  sme_lanes_t             vec_q;
  sme_lanes_t             vec_n;
  logic [NB-1:0]          nz_q;
  logic [NB-1:0]          nz_n;
  logic [NB-1:0]          keep_q;
  logic [NB-1:0]          keep_n;
  logic [NB-1:0]          rem_q;
  logic [NB-1:0]          rem_n;
  logic [NB-1:0]          low_q;
  logic [`SME_RULE_W-1:0] idx_n;

  // Lanes still to hand out, and the lowest of them as one-hot
  assign rem_q = nz_q & keep_q;
  assign low_q = rem_q & (~rem_q + 1'b1);

  // Fetch the next vector once the held one is used up
  assign pop = not_empty && rem_q == '0;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    vec_n  = vec_q;
    nz_n   = nz_q;
    keep_n = keep_q;
    if (pop) begin
      vec_n  = dout;
      keep_n = '1;
      for (int k = 0; k < NB; k++) begin
        nz_n[k] = dout.rule[k] != '0;
      end
    end else if (next_index && match_valid) begin
      keep_n = keep_q & ~low_q;
    end
  end

  assign rem_n = nz_n & keep_n;

  // Lowest remaining lane wins
  always_comb begin
    idx_n = '0;
    for (int k = NB - 1; k >= 0; k--) begin
      if (rem_n[k]) begin
        idx_n = vec_n.rule[k];
      end
    end
  end

  //////////////////////////////
  // Registers and outputs
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || reload) begin
      nz_q             <= '0;
      keep_q           <= '1;
      match_valid      <= 1'b0;
      match_valid_stat <= '0;
    end else begin
      nz_q             <= nz_n;
      keep_q           <= keep_n;
      match_valid      <= |rem_n;
      match_valid_stat <= rem_n;
    end
  end

  always_ff @(posedge clk) begin
    vec_q       <= vec_n;
    match_index <= idx_n;
  end

  // FIFO only ever holds vectors with a hit
  assert property (@(posedge clk) disable iff (rst)
    (pop && !reload) |=> match_valid);

endmodule

`default_nettype wire

// File: verilog/tail_keeper.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module tail_keeper
  import sme_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      reload,
  input  sme_beat_t s_beat,
  input  logic      s_fire,
  output sme_tail_t last_bytes
);

  localparam int NB = `SME_BYTES;
  localparam int TB = `SME_TAIL_BYTES;
  localparam int CW = $clog2(NB + 1);

  logic [8*NB-1:0]   chunk1_q;
  logic [8*NB-1:0]   chunk2_q;
  logic [CW-1:0]     cnt_q;
  logic [CW-1:0]     keep_cnt;
  logic              valid_q;
  logic [16*NB-1:0]  pair_shifted;

  // Number of kept bytes in the incoming beat
  always_comb begin
    keep_cnt = '0;
    for (int k = 0; k < NB; k++) begin
      if (s_beat.keep[k]) begin
        keep_cnt = keep_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      chunk2_q <= chunk1_q;
      chunk1_q <= s_beat.data;
      cnt_q    <= keep_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || reload) begin
      valid_q <= 1'b0;
    end else if (s_fire && s_beat.last) begin
      valid_q <= 1'b1;
    end
  end

  // Packet end sits at pair byte NB+cnt-1, so the tail starts at byte cnt+1
  assign pair_shifted = {chunk1_q, chunk2_q} >> (8 * (cnt_q + 1));

  assign last_bytes.bytes = pair_shifted[8*TB-1:0];
  assign last_bytes.count = 3'(TB);
  assign last_bytes.valid = valid_q;

endmodule

`default_nettype wire

// File: verilog/sme_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module sme_wrapper
  import sme_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  sme_beat_t              s_beat,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  sme_tail_t              preamble,
  input  logic                   reload,
  input  logic                   next_index,
  output logic [`SME_RULE_W-1:0] match_index,
  output logic                   match_valid,
  output logic [`SME_BYTES-1:0]  match_valid_stat,
  output sme_tail_t              last_bytes
);

  sme_beat_t  m_beat;
  logic       m_valid;
  logic       m_sop;
  logic       m_pre;
  logic       in_ready;
  logic       almost_full;
  logic       push;
  sme_lanes_t lanes;
  sme_lanes_t fifo_dout;
  logic       not_empty;
  logic       pop;
  logic       s_fire;

  assign s_fire = s_valid && s_ready;

  //////////////////////////////
  // Input side
  //////////////////////////////

  chunk_mux u_chunk_mux (
    .clk      (clk),
    .rst      (rst),
    .reload   (reload),
    .preamble (preamble),
    .s_beat   (s_beat),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .in_ready (in_ready),
    .m_beat   (m_beat),
    .m_valid  (m_valid),
    .m_sop    (m_sop),
    .m_pre    (m_pre)
  );

  pattern_matcher u_matcher (
    .clk         (clk),
    .rst         (rst),
    .m_beat      (m_beat),
    .m_valid     (m_valid),
    .m_sop       (m_sop),
    .m_pre       (m_pre),
    .in_ready    (in_ready),
    .almost_full (almost_full),
    .push        (push),
    .lanes       (lanes)
  );

  //////////////////////////////
  // Match output side
  //////////////////////////////

  match_fifo #(
    .payload_t (sme_lanes_t)
  ) u_fifo (
    .clk         (clk),
    .rst         (rst),
    .clear       (reload),
    .push        (push),
    .din         (lanes),
    .pop         (pop),
    .dout        (fifo_dout),
    .not_empty   (not_empty),
    .almost_full (almost_full)
  );

  match_selector u_selector (
    .clk              (clk),
    .rst              (rst),
    .reload           (reload),
    .dout             (fifo_dout),
    .not_empty        (not_empty),
    .pop              (pop),
    .next_index       (next_index),
    .match_index      (match_index),
    .match_valid      (match_valid),
    .match_valid_stat (match_valid_stat)
  );

  // Tail of each packet for the next preamble
  tail_keeper u_tail (
    .clk        (clk),
    .rst        (rst),
    .reload     (reload),
    .s_beat     (s_beat),
    .s_fire     (s_fire),
    .last_bytes (last_bytes)
  );

endmodule

`default_nettype wire

// File: sim/tb_sme.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_params.svh"

module tb_sme
  import sme_pkg::*;
();

  localparam int CYCLE_LIMIT = 4000;
  localparam int NB          = `SME_BYTES;
  localparam int TAIL        = `SME_TAIL_BYTES;
  localparam int HIST        = `SME_PAT_LEN - 1;
  localparam int RW          = `SME_RULE_W;

  logic              clk;
  logic              rst;
  sme_beat_t         s_beat;
  logic              s_valid;
  logic              s_ready;
  sme_tail_t         preamble;
  logic              reload;
  logic              next_index;
  logic [RW-1:0]     match_index;
  logic              match_valid;
  logic [NB-1:0]     match_valid_stat;
  sme_tail_t         last_bytes;
  logic              s_fire;

  // Reference model and bookkeeping
  logic [31:0]       lfsr;
  logic [7:0]        win_q[$];
  logic [7:0]        pkt_q[$];
  logic [RW-1:0]     exp_q[$];
  logic [RW-1:0]     exp_head;
  logic [8*TAIL-1:0] exp_tail_next;
  logic [8*TAIL-1:0] exp_tail = '0;
  logic              quiet;
  logic              send_done;
  int                cycle_cnt = 0;
  int                stall_cycles = 0;
  int                assert_errs = 0;
  int                proc_errs = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                errs_before = 0;

  sme_wrapper i_dut (
    .clk              (clk),
    .rst              (rst),
    .s_beat           (s_beat),
    .s_valid          (s_valid),
    .s_ready          (s_ready),
    .preamble         (preamble),
    .reload           (reload),
    .next_index       (next_index),
    .match_index      (match_index),
    .match_valid      (match_valid),
    .match_valid_stat (match_valid_stat),
    .last_bytes       (last_bytes)
  );

  assign s_fire = s_valid && s_ready;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit and stall counter
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (s_valid && !s_ready && !rst) begin
      stall_cycles <= stall_cycles + 1;
    end
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Expected tail is latched when the packet end is taken
  always @(posedge clk) begin
    if (s_fire && s_beat.last) begin
      exp_tail <= exp_tail_next;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge clk) disable iff (rst)
    (next_index && match_valid) |-> match_index == exp_head)
  else begin
    assert_errs = assert_errs + 1;
    $display("Fail at %0t ns: match_index %0d, expected %0d",
             $time, $sampled(match_index), exp_head);
  end

  // Lowest remaining lane drops out on each index
  assert property (@(posedge clk) disable iff (rst)
    (next_index && match_valid) |=>
      match_valid_stat == ($past(match_valid_stat) & ($past(match_valid_stat) - NB'(1))))
  else begin
    assert_errs = assert_errs + 1;
    $display("Fail at %0t ns: match_valid_stat %b after next_index", $time, match_valid_stat);
  end

  assert property (@(posedge clk) disable iff (rst)
    (next_index && match_valid && $onehot(match_valid_stat)) |=> !match_valid)
  else begin
    assert_errs = assert_errs + 1;
    $display("Fail at %0t ns: match_valid still high after the last index", $time);
  end

  assert property (@(posedge clk) disable iff (rst)
    quiet |-> !match_valid)
  else begin
    assert_errs = assert_errs + 1;
    $display("Fail at %0t ns: match_valid high with rule %0d, none expected",
             $time, $sampled(match_index));
  end

  assert property (@(posedge clk) disable iff (rst)
    (s_fire && s_beat.last) |=> (last_bytes.valid && last_bytes.bytes == exp_tail &&
                                 last_bytes.count == 3'(TAIL)))
  else begin
    assert_errs = assert_errs + 1;
    $display("Fail at %0t ns: last_bytes %h valid %b count %0d, expected %h",
             $time, last_bytes.bytes, last_bytes.valid, last_bytes.count, exp_tail);
  end

  assert property (@(posedge clk) disable iff (rst)
    reload |=> !last_bytes.valid)
  else begin
    assert_errs = assert_errs + 1;
    $display("Fail at %0t ns: last_bytes.valid not cleared by reload", $time);
  end

  //////////////////////////////
  // Model and stimulus helpers
  //////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return b;
  endfunction

  // Lower case letters never start or continue a pattern
  function automatic logic [7:0] filler_byte();
    logic [4:0] v;
    for (int i = 0; i < 5; i++) begin
      v[i] = lfsr_bit();
    end
    return 8'h61 + 8'(v % 5'd26);
  endfunction

  function automatic logic [8*NB-1:0] filler_beat();
    logic [8*NB-1:0] d;
    for (int i = 0; i < NB; i++) begin
      d[8*i +: 8] = filler_byte();
    end
    return d;
  endfunction

  // Pattern k is four consecutive letters from 'A'+k, rule k+1
  function automatic logic [RW-1:0] match_rule(input logic [7:0] b0, input logic [7:0] b1,
                                               input logic [7:0] b2, input logic [7:0] b3);
    logic [RW-1:0] rule;
    rule = '0;
    for (int k = 0; k < 8; k++) begin
      if (b0 == 8'(65 + k) && b1 == 8'(66 + k) && b2 == 8'(67 + k) && b3 == 8'(68 + k)) begin
        rule = RW'(k + 1);
      end
    end
    return rule;
  endfunction

  task automatic model_beat(input logic [8*NB-1:0] data, input logic [NB-1:0] keep,
                            input logic last);
    logic [RW-1:0] rule;
    int            n;
    for (int k = 0; k < NB; k++) begin
      if (keep[k]) begin
        win_q.push_back(data[8*k +: 8]);
        pkt_q.push_back(data[8*k +: 8]);
        if (win_q.size() == HIST + 1) begin
          rule = match_rule(win_q[0], win_q[1], win_q[2], win_q[3]);
          if (rule != '0) begin
            exp_q.push_back(rule);
          end
          void'(win_q.pop_front());
        end
      end
    end
    if (last) begin
      n = pkt_q.size();
      for (int i = 0; i < TAIL; i++) begin
        exp_tail_next[8*i +: 8] = pkt_q[n - TAIL + i];
      end
      win_q.delete();
      pkt_q.delete();
    end
  endtask

  // A preamble only seeds the history of the next packet
  task automatic do_reload(input logic pv, input logic [8*TAIL-1:0] pbytes);
    preamble = '{bytes: pbytes, count: 3'(TAIL), valid: pv};
    reload = 1'b1;
    win_q.delete();
    pkt_q.delete();
    if (pv) begin
      for (int i = TAIL - HIST; i < TAIL; i++) begin
        win_q.push_back(pbytes[8*i +: 8]);
      end
    end
    @(posedge clk);
    #1;
    reload = 1'b0;
  endtask

  task automatic send_beat(input logic [8*NB-1:0] data, input logic [NB-1:0] keep,
                           input logic last);
    logic took;
    model_beat(data, keep, last);
    s_beat = '{data: data, keep: keep, last: last};
    s_valid = 1'b1;
    took = 1'b0;
    while (!took) begin
      took = s_ready;
      @(posedge clk);
      #1;
    end
    s_valid = 1'b0;
  endtask

  // One next_index pulse per expected rule, with a gap cycle between
  task automatic drain_matches();
    while (exp_q.size() > 0 || !send_done) begin
      if (match_valid && exp_q.size() > 0) begin
        exp_head = exp_q.pop_front();
        next_index = 1'b1;
        @(posedge clk);
        #1;
        next_index = 1'b0;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    quiet = 1'b1;
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
    quiet = 1'b0;
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = assert_errs + proc_errs - errs_before;
    tests_run = tests_run + 1;
    if (errs == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errs);
    end
    errs_before = assert_errs + proc_errs;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [8*NB-1:0]   d;
    logic [8*NB-1:0]   pkt;
    logic [8*TAIL-1:0] pre;
    logic [2:0]        k;
    logic [1:0]        ofs;
    int                stall_base;
    lfsr = 32'he2cf_ee7f;
    s_beat = '0;
    s_valid = 1'b0;
    preamble = '0;
    reload = 1'b0;
    next_index = 1'b0;
    exp_head = '0;
    exp_tail_next = '0;
    quiet = 1'b0;
    send_done = 1'b1;
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    do_reload(1'b0, '0);
    send_beat(64'h4847_4645_4443_4241, 8'hFF, 1'b1);
    drain_matches();
    expect_quiet(10);
    report_test("one beat ABCDEFGH");

    // "AB" closes the first beat, "CD" opens the second
    do_reload(1'b0, '0);
    d = filler_beat();
    d[63:48] = 16'h4241;
    send_beat(d, 8'hFF, 1'b0);
    d = filler_beat();
    d[15:0] = 16'h4443;
    send_beat(d, 8'hFF, 1'b1);
    drain_matches();
    expect_quiet(10);
    report_test("pattern across beats");

    // Preamble ends in "ABCD" which must stay silent, packet starts with "E"
    d = filler_beat();
    pre = d[8*TAIL-1:0];
    pre[55:24] = 32'h4443_4241;
    pkt = filler_beat();
    pkt[7:0] = 8'h45;
    do_reload(1'b1, pre);
    send_beat(pkt, 8'hFF, 1'b1);
    drain_matches();
    expect_quiet(10);
    do_reload(1'b0, pre);
    send_beat(pkt, 8'hFF, 1'b1);
    drain_matches();
    expect_quiet(12);
    report_test("preamble seeds history");

    do_reload(1'b0, '0);
    stall_base = stall_cycles;
    send_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          d = filler_beat();
          k = {lfsr_bit(), lfsr_bit(), lfsr_bit()};
          ofs = {lfsr_bit(), lfsr_bit()};
          d[8*ofs +: 32] = {8'(68 + k), 8'(67 + k), 8'(66 + k), 8'(65 + k)};
          send_beat(d, 8'hFF, i == 7);
        end
        send_done = 1'b1;
      end
      begin
        // Hold off consuming until the input stalls or every beat is in
        while (stall_cycles == stall_base && !send_done) begin
          @(posedge clk);
          #1;
        end
        repeat (4) begin
          @(posedge clk);
          #1;
        end
        drain_matches();
      end
    join
    assert (stall_cycles > stall_base) else begin
      proc_errs = proc_errs + 1;
      $display("s_ready never went low while matches were held back");
    end
    expect_quiet(10);
    report_test("back-pressure");

    // Partial last beat ends with "HIJK"
    do_reload(1'b0, '0);
    send_beat(filler_beat(), 8'hFF, 1'b0);
    d = filler_beat();
    d[39:8] = 32'h4B4A_4948;
    d[63:40] = '0;
    send_beat(d, 8'h1F, 1'b1);
    drain_matches();
    expect_quiet(6);
    do_reload(1'b0, '0);
    expect_quiet(3);
    report_test("tail after partial beat");

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, assert_errs + proc_errs);
    if (tests_failed == 0 && assert_errs + proc_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/sme_pkg.sv
verilog/chunk_mux.sv
verilog/pattern_matcher.sv
verilog/match_fifo.sv
verilog/match_selector.sv
verilog/tail_keeper.sv
verilog/sme_wrapper.sv
sim/tb_sme.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_sme \
  -f list.f -o tb_sme_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_sme_sim > sim.log 2>&1
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log && echo "Simulation passed" \
  || { echo "No pass status in sim.log"; exit 1; }
